/* verilog/gb_platform_pkg.sv */
package gb_platform_pkg;

    // ==========================================================
    // Vector types
    // ==========================================================

    // One ROM byte, or one 8-bit colour channel
    typedef logic [7:0]  byte_t;

    // External memory data word
    typedef logic [15:0] mem_word_t;

    // Word address towards the external memory
    typedef logic [23:0] mem_addr_t;

    // Byte address from the cartridge mapper
    typedef logic [22:0] mbc_addr_t;

    // Loader byte address and file index
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [7:0]  ioctl_index_t;

    // Memory byte enables, bit 1 is the upper byte
    typedef logic [1:0]  byte_lanes_t;

    // GBC pixel, red in the top five bits, blue at the bottom
    typedef logic [14:0] rgb555_t;

    // DMG pixel code, 0 lightest
    typedef logic [1:0]  dmg_shade_t;

    // LCD mode code as driven by the core's video unit
    typedef logic [1:0]  lcd_mode_t;

    // ==========================================================
    // Constants
    // ==========================================================

    // Modes 2 (OAM scan) and 3 (transfer) are not needed here
    localparam lcd_mode_t LCD_MODE_HBLANK = 2'd0;
    localparam lcd_mode_t LCD_MODE_VBLANK = 2'd1;

    // Loader indexes that carry a cartridge ROM
    // Low six bits of 1 cover every ROM slot in the file menu
    localparam logic [5:0]   IDX_ROM_LOW  = 6'h01;
    localparam ioctl_index_t IDX_BOOT_ROM = 8'h00;
    localparam ioctl_index_t IDX_ROM_ALT  = 8'h80;

    // DMG grey levels, shade 0 is white
    localparam byte_t SHADE_WHITE = 8'hFF;
    localparam byte_t SHADE_LIGHT = 8'hAA;
    localparam byte_t SHADE_DARK  = 8'h55;
    localparam byte_t SHADE_BLACK = 8'h00;

endpackage

/* verilog/clock_enable_gen.sv */
module clock_enable_gen
    import gb_platform_pkg::*;
#(
    parameter int CPU_DIV_WIDTH = 4,
    parameter int RTC_DIV_WIDTH = 11
) (
    input  logic clk_sys,
    input  logic reset,
    output logic ce_cpu,
    output logic ce_cpu_n,
    output logic ce_cpu2x,
    output logic ce_32k
);

    // Opposite phase point of the CPU divider, half a period in
    localparam logic [CPU_DIV_WIDTH-1:0] CPU_HALF = {1'b1, {(CPU_DIV_WIDTH-1){1'b0}}};

    logic [CPU_DIV_WIDTH-1:0] cpu_div;
    logic [CPU_DIV_WIDTH-1:0] cpu_div_next;
    logic [RTC_DIV_WIDTH-1:0] rtc_div;
    logic [RTC_DIV_WIDTH-1:0] rtc_div_next;

    assign cpu_div_next = cpu_div + 1'b1;
    assign rtc_div_next = rtc_div + 1'b1;

    // ==========================================================
    // Dividers and enable registers
    // ==========================================================

    // Enables decode the next count, so each pulse lands on the
    // same edge as the counter step that wraps it
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_div  <= '0;
            rtc_div  <= '0;
            ce_cpu   <= 1'b0;
            ce_cpu_n <= 1'b0;
            ce_cpu2x <= 1'b0;
            ce_32k   <= 1'b0;
        end else begin
            cpu_div  <= cpu_div_next;
            rtc_div  <= rtc_div_next;
            ce_cpu   <= (cpu_div_next == '0);
            // Half period later for the falling CPU phase
            ce_cpu_n <= (cpu_div_next == CPU_HALF);
            // Double rate, both phases
            ce_cpu2x <= (cpu_div_next[CPU_DIV_WIDTH-2:0] == '0);
            // Slow tick for the cartridge RTC
            ce_32k   <= (rtc_div_next == '0);
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // The two CPU phases never coincide
    assert property (@(posedge clk_sys) disable iff (reset) !(ce_cpu && ce_cpu_n))
        else $error("ce_cpu and ce_cpu_n high together");

    // Double-rate enable covers both CPU phases
    assert property (@(posedge clk_sys) disable iff (reset) (ce_cpu || ce_cpu_n) |-> ce_cpu2x)
        else $error("ce_cpu2x missing on a CPU phase");

endmodule

/* verilog/cart_memory_port.sv */
module cart_memory_port
    import gb_platform_pkg::*;
(
    // Loader stream
    input  logic         ioctl_download,
    input  logic         ioctl_wr,
    input  ioctl_index_t ioctl_index,
    input  ioctl_addr_t  ioctl_addr,
    input  mem_word_t    ioctl_dout,
    // Mapper side
    input  mbc_addr_t    mbc_addr,
    input  logic         cart_rd,
    input  logic         cram_rd,
    // Memory read data
    input  mem_word_t    mem_dout,
    // Outputs
    output logic         cart_download,
    output mem_addr_t    mem_addr,
    output mem_word_t    mem_din,
    output byte_lanes_t  mem_ds,
    output logic         mem_oe,
    output logic         mem_we,
    output byte_t        rom_do
);

    logic rom_index;

    // ==========================================================
    // Download detection
    // ==========================================================

    // Any ROM slot, the boot slot, or the alternate ROM index
    assign rom_index = (ioctl_index[5:0] == IDX_ROM_LOW)
                    || (ioctl_index == IDX_BOOT_ROM)
                    || (ioctl_index == IDX_ROM_ALT);

    assign cart_download = ioctl_download && rom_index;

    // ==========================================================
    // Memory request mux
    // ==========================================================

    always_comb begin
        if (cart_download) begin
            // Loader owns the memory, whole words at a time
            mem_addr = ioctl_addr[24:1];
            mem_din  = ioctl_dout;
            mem_ds   = 2'b11;
            mem_we   = ioctl_wr;
            mem_oe   = 1'b0;
        end else begin
            // Mapper reads, top address bits held at zero
            mem_addr = {2'b00, mbc_addr[22:1]};
            mem_din  = '0;
            // Odd byte lives in the upper lane
            mem_ds   = {mbc_addr[0], ~mbc_addr[0]};
            mem_we   = 1'b0;
            // Cartridge RAM reads are served elsewhere
            mem_oe   = cart_rd && !cram_rd;
        end

        // Read and write requests never overlap
        assert (!(mem_oe && mem_we))
            else $error("mem_oe and mem_we high together");
    end

    // ==========================================================
    // ROM byte select
    // ==========================================================

    // Little-endian word, odd addresses take the high byte
    assign rom_do = mbc_addr[0] ? mem_dout[15:8] : mem_dout[7:0];

endmodule

/* verilog/video_output.sv */
module video_output
    import gb_platform_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    // LCD side of the core
    input  lcd_mode_t  lcd_mode,
    input  rgb555_t    lcd_data,
    input  dmg_shade_t lcd_data_gb,
    input  logic       lcd_vsync,
    input  logic       is_gbc_game,
    // Video out
    output byte_t      vga_r,
    output byte_t      vga_g,
    output byte_t      vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_hb,
    output logic       vga_vb
);

    byte_t dmg_grey;
    byte_t gbc_r;
    byte_t gbc_g;
    byte_t gbc_b;
    logic  in_hblank;
    logic  last_hblank;

    // ==========================================================
    // Colour conversion
    // ==========================================================

    // DMG shade code to grey level
    always_comb begin
        case (lcd_data_gb)
            2'd0:    dmg_grey = SHADE_WHITE;
            2'd1:    dmg_grey = SHADE_LIGHT;
            2'd2:    dmg_grey = SHADE_DARK;
            default: dmg_grey = SHADE_BLACK;
        endcase
    end

    // RGB555 to RGB888, top bits repeated into the low bits
    // so full scale maps to FF and zero stays zero
    assign gbc_r = {lcd_data[14:10], lcd_data[14:12]};
    assign gbc_g = {lcd_data[9:5], lcd_data[9:7]};
    assign gbc_b = {lcd_data[4:0], lcd_data[4:2]};

    // Game type picks colour or grey on all three channels
    assign vga_r = is_gbc_game ? gbc_r : dmg_grey;
    assign vga_g = is_gbc_game ? gbc_g : dmg_grey;
    assign vga_b = is_gbc_game ? gbc_b : dmg_grey;

    // ==========================================================
    // Sync and blanking
    // ==========================================================

    assign in_hblank = (lcd_mode == LCD_MODE_HBLANK);

    // One-cycle low pulse on each fresh entry into HBLANK
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            last_hblank <= 1'b0;
            vga_hs      <= 1'b1;
        end else begin
            last_hblank <= in_hblank;
            vga_hs      <= !(in_hblank && !last_hblank);
        end
    end

    // Vertical sync is active low towards the display
    assign vga_vs = ~lcd_vsync;

    // Blanking flags straight from the mode code
    assign vga_hb = in_hblank;
    assign vga_vb = (lcd_mode == LCD_MODE_VBLANK);

    // ==========================================================
    // Checks
    // ==========================================================

    // Sync pulse stays one cycle wide, even when HBLANK lingers
    assert property (@(posedge clk_sys) disable iff (reset) !vga_hs |=> vga_hs)
        else $error("vga_hs low for two cycles");

endmodule

/* verilog/gb_platform_top.sv */
module gb_platform_top
    import gb_platform_pkg::*;
#(
    parameter int CPU_DIV_WIDTH = 4,
    parameter int RTC_DIV_WIDTH = 11
) (
    input  logic         clk_sys,
    input  logic         reset,
    // Loader
    input  logic         ioctl_download,
    input  logic         ioctl_wr,
    input  ioctl_index_t ioctl_index,
    input  ioctl_addr_t  ioctl_addr,
    input  mem_word_t    ioctl_dout,
    // Mapper
    input  mbc_addr_t    mbc_addr,
    input  logic         cart_rd,
    input  logic         cram_rd,
    // External memory
    input  mem_word_t    mem_dout,
    output mem_addr_t    mem_addr,
    output mem_word_t    mem_din,
    output byte_lanes_t  mem_ds,
    output logic         mem_oe,
    output logic         mem_we,
    // Cartridge
    output byte_t        rom_do,
    output logic         cart_download,
    // Clock enables
    output logic         ce_cpu,
    output logic         ce_cpu_n,
    output logic         ce_cpu2x,
    output logic         ce_32k,
    // LCD
    input  lcd_mode_t    lcd_mode,
    input  rgb555_t      lcd_data,
    input  dmg_shade_t   lcd_data_gb,
    input  logic         lcd_vsync,
    input  logic         is_gbc_game,
    // Video
    output byte_t        vga_r,
    output byte_t        vga_g,
    output byte_t        vga_b,
    output logic         vga_hs,
    output logic         vga_vs,
    output logic         vga_hb,
    output logic         vga_vb
);

    // ==========================================================
    // Clock enables
    // ==========================================================

    clock_enable_gen #(
        .CPU_DIV_WIDTH (CPU_DIV_WIDTH),
        .RTC_DIV_WIDTH (RTC_DIV_WIDTH)
    ) u_clock_enable_gen (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .ce_cpu   (ce_cpu),
        .ce_cpu_n (ce_cpu_n),
        .ce_cpu2x (ce_cpu2x),
        .ce_32k   (ce_32k)
    );

    // ==========================================================
    // Cartridge memory port
    // ==========================================================

    cart_memory_port u_cart_memory_port (
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .mbc_addr       (mbc_addr),
        .cart_rd        (cart_rd),
        .cram_rd        (cram_rd),
        .mem_dout       (mem_dout),
        .cart_download  (cart_download),
        .mem_addr       (mem_addr),
        .mem_din        (mem_din),
        .mem_ds         (mem_ds),
        .mem_oe         (mem_oe),
        .mem_we         (mem_we),
        .rom_do         (rom_do)
    );

    // ==========================================================
    // Video output
    // ==========================================================

    video_output u_video_output (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .lcd_mode    (lcd_mode),
        .lcd_data    (lcd_data),
        .lcd_data_gb (lcd_data_gb),
        .lcd_vsync   (lcd_vsync),
        .is_gbc_game (is_gbc_game),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_hb      (vga_hb),
        .vga_vb      (vga_vb)
    );

endmodule

/* testbench/gb_platform_checker.sv */
module gb_platform_checker
    import gb_platform_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    // LCD inputs that the sync and blanking model follows
    input  lcd_mode_t   lcd_mode,
    input  logic        lcd_vsync,
    // DUT outputs
    input  mem_addr_t   mem_addr,
    input  mem_word_t   mem_din,
    input  byte_lanes_t mem_ds,
    input  logic        mem_oe,
    input  logic        mem_we,
    input  byte_t       rom_do,
    input  logic        cart_download,
    input  logic        ce_cpu,
    input  logic        ce_cpu_n,
    input  logic        ce_cpu2x,
    input  logic        ce_32k,
    input  byte_t       vga_r,
    input  byte_t       vga_g,
    input  byte_t       vga_b,
    input  logic        vga_hs,
    input  logic        vga_vs,
    input  logic        vga_hb,
    input  logic        vga_vb,
    // Current vector and its expected values
    input  logic        vec_valid,
    input  mem_addr_t   exp_mem_addr,
    input  mem_word_t   exp_mem_din,
    input  byte_lanes_t exp_mem_ds,
    input  logic        exp_mem_oe,
    input  logic        exp_mem_we,
    input  byte_t       exp_rom_do,
    input  logic        exp_cart_download,
    input  byte_t       exp_vga_r,
    input  byte_t       exp_vga_g,
    input  byte_t       exp_vga_b,
    // Results
    output logic        enable_done,
    output int          cart_errors,
    output int          video_errors,
    output int          sync_errors,
    output int          enable_errors
);

    // Enable periods at the default divider widths
    localparam int CPU_PERIOD          = 16;
    localparam int CPU2X_PERIOD        = 8;
    localparam int RTC_PERIOD          = 2048;
    localparam int ENABLE_CHECK_CYCLES = 4200;

    logic reset_seen = 1'b0;
    logic prev_hblank;
    logic exp_hs;
    logic in_hblank;
    // Edges seen since reset release
    int   cycle_n;

    assign in_hblank   = (lcd_mode == LCD_MODE_HBLANK);
    assign enable_done = (cycle_n > ENABLE_CHECK_CYCLES);

    function automatic int check_field(input string name, input logic [31:0] expected,
                                       input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // Enable due in cycle n for a given period and phase offset
    function automatic logic phase_hit(input int n, input int period, input int offset);
        return (n > 0) && (n >= offset) && ((n - offset) % period == 0);
    endfunction

    // ============================================================
    // Sampling on the rising edge, before any flop moves
    // ============================================================

    always @(posedge clk_sys) begin
        if (reset) begin
            // DUT outputs are defined once the first reset edge is in
            if (reset_seen) begin
                enable_errors += check_field("ce_cpu", 32'd0, 32'(ce_cpu));
                enable_errors += check_field("ce_cpu_n", 32'd0, 32'(ce_cpu_n));
                enable_errors += check_field("ce_cpu2x", 32'd0, 32'(ce_cpu2x));
                enable_errors += check_field("ce_32k", 32'd0, 32'(ce_32k));
            end
            reset_seen  <= 1'b1;
            cycle_n     <= 0;
            prev_hblank <= 1'b0;
            exp_hs      <= 1'b1;
        end else begin
            // Cartridge port and colour from the vector file
            if (vec_valid) begin
                cart_errors += check_field("mem_addr", 32'(exp_mem_addr), 32'(mem_addr));
                cart_errors += check_field("mem_din", 32'(exp_mem_din), 32'(mem_din));
                cart_errors += check_field("mem_ds", 32'(exp_mem_ds), 32'(mem_ds));
                cart_errors += check_field("mem_oe", 32'(exp_mem_oe), 32'(mem_oe));
                cart_errors += check_field("mem_we", 32'(exp_mem_we), 32'(mem_we));
                cart_errors += check_field("rom_do", 32'(exp_rom_do), 32'(rom_do));
                cart_errors += check_field("cart_download", 32'(exp_cart_download),
                                           32'(cart_download));
                video_errors += check_field("vga_r", 32'(exp_vga_r), 32'(vga_r));
                video_errors += check_field("vga_g", 32'(exp_vga_g), 32'(vga_g));
                video_errors += check_field("vga_b", 32'(exp_vga_b), 32'(vga_b));
            end
            // Blanking and vertical sync follow the LCD every cycle
            video_errors += check_field("vga_hb", 32'(in_hblank), 32'(vga_hb));
            video_errors += check_field("vga_vb", 32'(lcd_mode == LCD_MODE_VBLANK),
                                        32'(vga_vb));
            video_errors += check_field("vga_vs", 32'(!lcd_vsync), 32'(vga_vs));
            sync_errors  += check_field("vga_hs", 32'(exp_hs), 32'(vga_hs));
            // Enables within the checked window
            if (cycle_n <= ENABLE_CHECK_CYCLES) begin
                enable_errors += check_field("ce_cpu",
                    32'(phase_hit(cycle_n, CPU_PERIOD, 0)), 32'(ce_cpu));
                enable_errors += check_field("ce_cpu_n",
                    32'(phase_hit(cycle_n, CPU_PERIOD, CPU_PERIOD / 2)), 32'(ce_cpu_n));
                enable_errors += check_field("ce_cpu2x",
                    32'(phase_hit(cycle_n, CPU2X_PERIOD, 0)), 32'(ce_cpu2x));
                enable_errors += check_field("ce_32k",
                    32'(phase_hit(cycle_n, RTC_PERIOD, 0)), 32'(ce_32k));
            end
            cycle_n     <= cycle_n + 1;
            // Sync low only after a fresh HBLANK entry
            exp_hs      <= !(in_hblank && !prev_hblank);
            prev_hblank <= in_hblank;
        end
    end

endmodule

/* testbench/tb_gb_platform.sv */
module tb_gb_platform
    import gb_platform_pkg::*;
();

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_VECTORS  = 28;
    localparam int NUM_FIELDS   = 24;
    // Reset, vectors, enable window and a margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + 4200 + 100;
    localparam string VECTOR_FILE = "testbench/gb_platform_vectors.txt";

    // Column positions within one vector line
    localparam int F_DL    = 0;
    localparam int F_WR    = 1;
    localparam int F_IDX   = 2;
    localparam int F_IADDR = 3;
    localparam int F_IDOUT = 4;
    localparam int F_MBC   = 5;
    localparam int F_CRD   = 6;
    localparam int F_CRAM  = 7;
    localparam int F_MDOUT = 8;
    localparam int F_MODE  = 9;
    localparam int F_LCD   = 10;
    localparam int F_GB    = 11;
    localparam int F_VS    = 12;
    localparam int F_GBC   = 13;
    // Expected columns follow the stimulus
    localparam int X_MADDR = 14;
    localparam int X_MDIN  = 15;
    localparam int X_DS    = 16;
    localparam int X_OE    = 17;
    localparam int X_WE    = 18;
    localparam int X_ROM   = 19;
    localparam int X_CDL   = 20;
    localparam int X_R     = 21;
    localparam int X_G     = 22;
    localparam int X_B     = 23;

    logic [31:0] vector_mem [0:NUM_VECTORS*NUM_FIELDS-1];

    logic         clk_sys = 1'b0;
    logic         reset;
    logic         ioctl_download, ioctl_wr;
    ioctl_index_t ioctl_index;
    ioctl_addr_t  ioctl_addr;
    mem_word_t    ioctl_dout;
    mbc_addr_t    mbc_addr;
    logic         cart_rd, cram_rd;
    mem_word_t    mem_dout;
    lcd_mode_t    lcd_mode;
    rgb555_t      lcd_data;
    dmg_shade_t   lcd_data_gb;
    logic         lcd_vsync, is_gbc_game;

    mem_addr_t    mem_addr;
    mem_word_t    mem_din;
    byte_lanes_t  mem_ds;
    logic         mem_oe, mem_we, cart_download;
    byte_t        rom_do, vga_r, vga_g, vga_b;
    logic         ce_cpu, ce_cpu_n, ce_cpu2x, ce_32k;
    logic         vga_hs, vga_vs, vga_hb, vga_vb;

    // Expected values that travel with the current vector
    logic         vec_valid;
    mem_addr_t    exp_mem_addr;
    mem_word_t    exp_mem_din;
    byte_lanes_t  exp_mem_ds;
    logic         exp_mem_oe, exp_mem_we, exp_cart_download;
    byte_t        exp_rom_do, exp_vga_r, exp_vga_g, exp_vga_b;

    logic enable_done;
    int   cart_errors, video_errors, sync_errors, enable_errors;
    int   total_errors;
    int   cycle_count;

    always #CLK_HALF clk_sys = ~clk_sys;

    gb_platform_top #(
        .CPU_DIV_WIDTH (4),
        .RTC_DIV_WIDTH (11)
    ) DUT (.*);

    // Comparison and error counting
    gb_platform_checker u_checker (.*);

    // ============================================================
    // Stimulus
    // ============================================================

    // Quiet inputs with the LCD parked in transfer mode
    task automatic drive_idle();
        {ioctl_download, ioctl_wr, cart_rd, cram_rd} = 4'b0000;
        ioctl_index = '0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        mbc_addr    = '0;
        mem_dout    = '0;
        lcd_mode    = 2'd3;
        lcd_data    = '0;
        lcd_data_gb = '0;
        lcd_vsync   = 1'b0;
        is_gbc_game = 1'b0;
        vec_valid   = 1'b0;
    endtask

    // One line of the file onto the DUT inputs and the checker
    task automatic apply_vector(input int idx);
        int base;
        base = idx * NUM_FIELDS;
        ioctl_download    = vector_mem[base + F_DL][0];
        ioctl_wr          = vector_mem[base + F_WR][0];
        ioctl_index       = vector_mem[base + F_IDX][7:0];
        ioctl_addr        = vector_mem[base + F_IADDR][24:0];
        ioctl_dout        = vector_mem[base + F_IDOUT][15:0];
        mbc_addr          = vector_mem[base + F_MBC][22:0];
        cart_rd           = vector_mem[base + F_CRD][0];
        cram_rd           = vector_mem[base + F_CRAM][0];
        mem_dout          = vector_mem[base + F_MDOUT][15:0];
        lcd_mode          = vector_mem[base + F_MODE][1:0];
        lcd_data          = vector_mem[base + F_LCD][14:0];
        lcd_data_gb       = vector_mem[base + F_GB][1:0];
        lcd_vsync         = vector_mem[base + F_VS][0];
        is_gbc_game       = vector_mem[base + F_GBC][0];
        // Expected side of the line
        exp_mem_addr      = vector_mem[base + X_MADDR][23:0];
        exp_mem_din       = vector_mem[base + X_MDIN][15:0];
        exp_mem_ds        = vector_mem[base + X_DS][1:0];
        exp_mem_oe        = vector_mem[base + X_OE][0];
        exp_mem_we        = vector_mem[base + X_WE][0];
        exp_rom_do        = vector_mem[base + X_ROM][7:0];
        exp_cart_download = vector_mem[base + X_CDL][0];
        exp_vga_r         = vector_mem[base + X_R][7:0];
        exp_vga_g         = vector_mem[base + X_G][7:0];
        exp_vga_b         = vector_mem[base + X_B][7:0];
        vec_valid         = 1'b1;
    endtask

    initial begin
        drive_idle();
        {exp_mem_addr, exp_mem_din, exp_mem_ds} = '0;
        {exp_mem_oe, exp_mem_we, exp_cart_download} = '0;
        {exp_rom_do, exp_vga_r, exp_vga_g, exp_vga_b} = '0;
        reset = 1'b1;
        $readmemh(VECTOR_FILE, vector_mem);
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #DRIVE_DELAY;
        reset = 1'b0;
        // One vector per cycle
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk_sys);
            #DRIVE_DELAY;
            apply_vector(i);
        end
        @(posedge clk_sys);
        #DRIVE_DELAY;
        drive_idle();
        // Enable window runs on past the vectors
        wait (enable_done);
        // Let the last checker edge settle before the totals
        @(posedge clk_sys);
        #DRIVE_DELAY;
        total_errors = cart_errors + video_errors + sync_errors + enable_errors;
        $display("Errors: cart %0d, video %0d, sync %0d, enables %0d, total %0d",
                 cart_errors, video_errors, sync_errors, enable_errors, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // ============================================================
    // Timeout
    // ============================================================

    // Cycle limit from reset, vector count and enable window
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, enable checks never finished", cycle_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* testbench/gb_platform_vectors.txt */
// dl wr idx ioctl_addr dout mbc_addr rd crd mdout md lcd gb vs gbc, then expected:
// mem_addr din ds oe we rom_do cdl r g b (one line per cycle, hex)
// ROM download routing
1 1 01 0000000 3E21 000000 0 0 0000 3 0000 0 0 0   000000 3E21 3 0 1 00 1 FF FF FF
1 0 01 0000002 C3A5 000000 1 0 0000 3 0000 1 0 0   000001 C3A5 3 0 0 00 1 AA AA AA
1 1 41 1FFFFFE FFFF 000001 0 0 1234 3 0000 2 0 0   FFFFFF FFFF 3 0 1 12 1 55 55 55
1 1 00 0123457 0102 000000 0 0 ABCD 0 0000 3 0 0   091A2B 0102 3 0 1 CD 1 00 00 00
1 0 80 0000100 5555 000000 0 0 0000 0 7FFF 0 0 1   000080 5555 3 0 0 00 1 FF FF FF
1 1 80 0000102 AAAA 000000 0 0 0000 2 0000 0 0 1   000081 AAAA 3 0 1 00 1 00 00 00
1 1 02 0000200 BEEF 000010 1 0 9876 1 0000 0 1 0   000008 0000 1 1 0 76 0 FF FF FF
1 0 02 0000000 0000 000011 1 1 9876 1 0000 1 1 0   000008 0000 2 0 0 98 0 AA AA AA
0 1 01 0000010 1111 000002 1 0 4321 0 0000 2 0 0   000001 0000 1 1 0 21 0 55 55 55
1 1 81 0000004 7E7E 000000 0 0 0000 3 0000 3 0 0   000002 7E7E 3 0 1 00 1 00 00 00
1 1 40 0000006 1357 000005 1 0 F00D 3 0000 0 0 0   000002 0000 2 1 0 F0 0 FF FF FF
// Play-mode reads with GBC colour
0 0 00 0000000 0000 000000 1 0 A55A 3 7C00 0 0 1   000000 0000 1 1 0 5A 0 FF 00 00
0 0 00 0000000 0000 000001 1 0 A55A 3 03E0 0 0 1   000000 0000 2 1 0 A5 0 00 FF 00
0 0 00 0000000 0000 7FFFFF 1 0 1E2D 0 001F 0 0 1   3FFFFF 0000 2 1 0 1E 0 00 00 FF
0 0 00 0000000 0000 7FFFFE 0 0 1E2D 0 2AA5 0 0 1   3FFFFF 0000 1 0 0 2D 0 52 AD 29
0 0 00 0000000 0000 123456 1 1 6789 2 061E 0 0 1   091A2B 0000 1 0 0 89 0 08 84 F7
0 0 00 0000000 0000 123457 0 1 6789 0 7C1F 0 0 1   091A2B 0000 2 0 0 67 0 FF 00 FF
0 0 00 0000000 0000 400000 1 0 00FF 1 4D87 0 1 1   200000 0000 1 1 0 FF 0 9C 63 39
0 0 00 0000000 0000 400001 1 0 00FF 0 7FFF 1 0 0   200000 0000 2 1 0 00 0 AA AA AA
// DMG shades and HBLANK entries
0 0 00 0000000 0000 000000 0 0 0000 3 0000 0 0 0   000000 0000 1 0 0 00 0 FF FF FF
0 0 00 0000000 0000 000000 0 0 0000 0 0000 1 0 0   000000 0000 1 0 0 00 0 AA AA AA
0 0 00 0000000 0000 000000 0 0 0000 0 0000 2 0 0   000000 0000 1 0 0 00 0 55 55 55
0 0 00 0000000 0000 000000 0 0 0000 0 7FFF 3 0 0   000000 0000 1 0 0 00 0 00 00 00
0 0 00 0000000 0000 000000 0 0 0000 2 0000 0 1 0   000000 0000 1 0 0 00 0 FF FF FF
0 0 00 0000000 0000 000000 0 0 0000 0 0421 2 0 1   000000 0000 1 0 0 00 0 08 08 08
0 0 00 0000000 0000 000000 0 0 0000 1 3DEF 0 1 1   000000 0000 1 0 0 00 0 7B 7B 7B
0 0 00 0000000 0000 000000 0 0 0000 0 4210 0 0 1   000000 0000 1 0 0 00 0 84 84 84
0 0 00 0000000 0000 000000 0 0 0000 3 0000 1 0 0   000000 0000 1 0 0 00 0 AA AA AA

/* compile.f */
verilog/gb_platform_pkg.sv
verilog/clock_enable_gen.sv
verilog/cart_memory_port.sv
verilog/video_output.sv
verilog/gb_platform_top.sv
testbench/gb_platform_checker.sv
testbench/tb_gb_platform.sv

/* Makefile */
# Verilator build and run of the platform testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_gb_platform \
		-f compile.f -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_gb_platform | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
